/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_cpu_top
FILELIST  ?= cpu_top.f
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)

/* cpu_top.f */
design/cpu_pkg.sv
design/pipe_ctrl_if.sv
design/register_file.sv
design/fetch_stage.sv
design/decode_stage.sv
design/hazard_unit.sv
design/execute_stage.sv
design/memory_stage.sv
design/cpu_top.sv
verification/tb_cpu_top.sv

/* design/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes the core executes
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    // Operand source picked in execute
    typedef enum logic [1:0] {
        FWD_REG   = 2'd0,
        FWD_EXMEM = 2'd1,
        FWD_MEMWB = 2'd2
    } fwd_sel_e;

    // All-zero value is a bubble
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    branch;
        logic    branch_ne;
    } ctrl_t;

    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire

/* design/cpu_top.sv */
`default_nettype none

module cpu_top #(
    parameter int DMEM_WORDS = 64
) (
    input  wire                            clk,
    input  wire                            rst_n_i,
    output wire  [cpu_pkg::XLEN-1:0]       imem_addr_o,
    input  wire  [cpu_pkg::XLEN-1:0]       imem_data_i,
    output wire                            wb_valid_o,
    output wire  [cpu_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output wire  [cpu_pkg::XLEN-1:0]       wb_data_o
);

    logic [cpu_pkg::XLEN-1:0]       id_pc;
    logic [cpu_pkg::XLEN-1:0]       id_instr;
    logic [cpu_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [cpu_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic                           use_rs1;
    logic                           use_rs2;
    logic [cpu_pkg::XLEN-1:0]       rs1_data;
    logic [cpu_pkg::XLEN-1:0]       rs2_data;
    cpu_pkg::fwd_sel_e              fwd_a;
    cpu_pkg::fwd_sel_e              fwd_b;
    logic [cpu_pkg::XLEN-1:0]       ex_pc;
    logic [cpu_pkg::XLEN-1:0]       ex_rs1_data;
    logic [cpu_pkg::XLEN-1:0]       ex_rs2_data;
    logic [cpu_pkg::XLEN-1:0]       ex_imm;
    logic [cpu_pkg::REG_ADDR_W-1:0] ex_rd;
    cpu_pkg::ctrl_t                 ex_ctrl;
    cpu_pkg::fwd_sel_e              ex_fwd_a;
    cpu_pkg::fwd_sel_e              ex_fwd_b;
    logic [cpu_pkg::XLEN-1:0]       mem_result;
    logic [cpu_pkg::XLEN-1:0]       mem_store_data;
    logic [cpu_pkg::REG_ADDR_W-1:0] mem_rd;
    cpu_pkg::ctrl_t                 mem_ctrl;

    pipe_ctrl_if u_pipe_ctrl ();

    fetch_stage u_fetch (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .ctrl       (u_pipe_ctrl.fetch),
        .instr_i    (imem_data_i),
        .pc_o       (imem_addr_o),
        .id_pc_o    (id_pc),
        .id_instr_o (id_instr)
    );

    decode_stage u_decode (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .ctrl          (u_pipe_ctrl.decode),
        .id_pc_i       (id_pc),
        .id_instr_i    (id_instr),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .use_rs1_o     (use_rs1),
        .use_rs2_o     (use_rs2),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .fwd_a_i       (fwd_a),
        .fwd_b_i       (fwd_b),
        .ex_pc_o       (ex_pc),
        .ex_rs1_data_o (ex_rs1_data),
        .ex_rs2_data_o (ex_rs2_data),
        .ex_imm_o      (ex_imm),
        .ex_rd_o       (ex_rd),
        .ex_ctrl_o     (ex_ctrl),
        .ex_fwd_a_o    (ex_fwd_a),
        .ex_fwd_b_o    (ex_fwd_b)
    );

    // Written from MEM/WB
    register_file u_regfile (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (wb_valid_o),
        .rd_i       (wb_rd_o),
        .wd_i       (wb_data_o)
    );

    hazard_unit u_hazard (
        .ctrl            (u_pipe_ctrl.hazard),
        .rs1_addr_i      (rs1_addr),
        .rs2_addr_i      (rs2_addr),
        .use_rs1_i       (use_rs1),
        .use_rs2_i       (use_rs2),
        .ex_rd_i         (ex_rd),
        .ex_mem_read_i   (ex_ctrl.mem_read),
        .ex_reg_write_i  (ex_ctrl.reg_write),
        .mem_rd_i        (mem_rd),
        .mem_reg_write_i (mem_ctrl.reg_write),
        .fwd_a_o         (fwd_a),
        .fwd_b_o         (fwd_b)
    );

    execute_stage u_execute (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .ctrl             (u_pipe_ctrl.execute),
        .ex_pc_i          (ex_pc),
        .ex_rs1_data_i    (ex_rs1_data),
        .ex_rs2_data_i    (ex_rs2_data),
        .ex_imm_i         (ex_imm),
        .ex_rd_i          (ex_rd),
        .ex_ctrl_i        (ex_ctrl),
        .ex_fwd_a_i       (ex_fwd_a),
        .ex_fwd_b_i       (ex_fwd_b),
        .wb_data_i        (wb_data_o),
        .mem_result_o     (mem_result),
        .mem_store_data_o (mem_store_data),
        .mem_rd_o         (mem_rd),
        .mem_ctrl_o       (mem_ctrl)
    );

    memory_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_memory (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .mem_result_i     (mem_result),
        .mem_store_data_i (mem_store_data),
        .mem_rd_i         (mem_rd),
        .mem_ctrl_i       (mem_ctrl),
        .wb_valid_o       (wb_valid_o),
        .wb_rd_o          (wb_rd_o),
        .wb_data_o        (wb_data_o)
    );

endmodule

`default_nettype wire

/* design/decode_stage.sv */
`default_nettype none

module decode_stage (
    input  wire                            clk,
    input  wire                            rst_n_i,
    pipe_ctrl_if.decode                    ctrl,
    input  wire  [cpu_pkg::XLEN-1:0]       id_pc_i,
    input  wire  [cpu_pkg::XLEN-1:0]       id_instr_i,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    output logic                           use_rs1_o,
    output logic                           use_rs2_o,
    input  wire  [cpu_pkg::XLEN-1:0]       rs1_data_i,
    input  wire  [cpu_pkg::XLEN-1:0]       rs2_data_i,
    input  wire  cpu_pkg::fwd_sel_e        fwd_a_i,
    input  wire  cpu_pkg::fwd_sel_e        fwd_b_i,
    output logic [cpu_pkg::XLEN-1:0]       ex_pc_o,
    output logic [cpu_pkg::XLEN-1:0]       ex_rs1_data_o,
    output logic [cpu_pkg::XLEN-1:0]       ex_rs2_data_o,
    output logic [cpu_pkg::XLEN-1:0]       ex_imm_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0] ex_rd_o,
    output cpu_pkg::ctrl_t                 ex_ctrl_o,
    output cpu_pkg::fwd_sel_e              ex_fwd_a_o,
    output cpu_pkg::fwd_sel_e              ex_fwd_b_o
);

    cpu_pkg::opcode_e         opcode;
    logic [2:0]               funct3;
    logic [6:0]               funct7;
    cpu_pkg::ctrl_t           dec_ctrl;
    logic [cpu_pkg::XLEN-1:0] imm;

    assign opcode     = cpu_pkg::opcode_e'(id_instr_i[6:0]);
    assign funct3     = id_instr_i[14:12];
    assign funct7     = id_instr_i[31:25];
    assign rs1_addr_o = id_instr_i[19:15];
    assign rs2_addr_o = id_instr_i[24:20];

    always_comb begin
        dec_ctrl  = '0;
        use_rs1_o = 1'b0;
        use_rs2_o = 1'b0;
        // I-type by default
        imm       = {{20{id_instr_i[31]}}, id_instr_i[31:20]};
        case (opcode)
            cpu_pkg::OPC_OP_IMM: begin
                // ADDI only
                dec_ctrl.use_imm   = 1'b1;
                dec_ctrl.reg_write = (funct3 == 3'b000);
                use_rs1_o          = 1'b1;
            end
            cpu_pkg::OPC_OP: begin
                dec_ctrl.reg_write = 1'b1;
                use_rs1_o          = 1'b1;
                use_rs2_o          = 1'b1;
                case (funct3)
                    3'b000: begin
                        dec_ctrl.alu_op = funct7[5] ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
                    end
                    3'b010: dec_ctrl.alu_op = cpu_pkg::ALU_SLT;
                    3'b100: dec_ctrl.alu_op = cpu_pkg::ALU_XOR;
                    3'b110: dec_ctrl.alu_op = cpu_pkg::ALU_OR;
                    3'b111: dec_ctrl.alu_op = cpu_pkg::ALU_AND;
                    default: dec_ctrl.reg_write = 1'b0;
                endcase
            end
            cpu_pkg::OPC_LOAD: begin
                dec_ctrl.use_imm   = 1'b1;
                dec_ctrl.mem_read  = 1'b1;
                dec_ctrl.reg_write = 1'b1;
                use_rs1_o          = 1'b1;
            end
            cpu_pkg::OPC_STORE: begin
                dec_ctrl.use_imm   = 1'b1;
                dec_ctrl.mem_write = 1'b1;
                use_rs1_o          = 1'b1;
                use_rs2_o          = 1'b1;
                imm = {{20{id_instr_i[31]}}, id_instr_i[31:25], id_instr_i[11:7]};
            end
            cpu_pkg::OPC_BRANCH: begin
                // BEQ is funct3 000, BNE is 001
                dec_ctrl.branch    = (funct3[2:1] == 2'b00);
                dec_ctrl.branch_ne = funct3[0];
                use_rs1_o          = 1'b1;
                use_rs2_o          = 1'b1;
                imm = {{19{id_instr_i[31]}}, id_instr_i[31], id_instr_i[7],
                       id_instr_i[30:25], id_instr_i[11:8], 1'b0};
            end
            default: begin
                dec_ctrl = '0;
            end
        endcase
    end

    // ID/EX control, bubbled on load-use stall or branch flush
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_ctrl_o  <= '0;
            ex_fwd_a_o <= cpu_pkg::FWD_REG;
            ex_fwd_b_o <= cpu_pkg::FWD_REG;
        end else begin
            if (ctrl.id_ex_bubble || ctrl.redirect) begin
                ex_ctrl_o <= '0;
            end else begin
                ex_ctrl_o <= dec_ctrl;
            end
            ex_fwd_a_o <= fwd_a_i;
            ex_fwd_b_o <= fwd_b_i;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc_o       <= id_pc_i;
        ex_rs1_data_o <= rs1_data_i;
        ex_rs2_data_o <= rs2_data_i;
        ex_imm_o      <= imm;
        ex_rd_o       <= id_instr_i[11:7];
    end

endmodule

`default_nettype wire

/* design/execute_stage.sv */
`default_nettype none

module execute_stage (
    input  wire                            clk,
    input  wire                            rst_n_i,
    pipe_ctrl_if.execute                   ctrl,
    input  wire  [cpu_pkg::XLEN-1:0]       ex_pc_i,
    input  wire  [cpu_pkg::XLEN-1:0]       ex_rs1_data_i,
    input  wire  [cpu_pkg::XLEN-1:0]       ex_rs2_data_i,
    input  wire  [cpu_pkg::XLEN-1:0]       ex_imm_i,
    input  wire  [cpu_pkg::REG_ADDR_W-1:0] ex_rd_i,
    input  wire  cpu_pkg::ctrl_t           ex_ctrl_i,
    input  wire  cpu_pkg::fwd_sel_e        ex_fwd_a_i,
    input  wire  cpu_pkg::fwd_sel_e        ex_fwd_b_i,
    input  wire  [cpu_pkg::XLEN-1:0]       wb_data_i,
    output logic [cpu_pkg::XLEN-1:0]       mem_result_o,
    output logic [cpu_pkg::XLEN-1:0]       mem_store_data_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0] mem_rd_o,
    output cpu_pkg::ctrl_t                 mem_ctrl_o
);

    logic [cpu_pkg::XLEN-1:0] op_a;
    logic [cpu_pkg::XLEN-1:0] op_b_reg;
    logic [cpu_pkg::XLEN-1:0] op_b;
    logic [cpu_pkg::XLEN-1:0] alu_res;

    function automatic logic [cpu_pkg::XLEN-1:0] pick(
        input cpu_pkg::fwd_sel_e        sel,
        input logic [cpu_pkg::XLEN-1:0] rf_val,
        input logic [cpu_pkg::XLEN-1:0] exmem_val,
        input logic [cpu_pkg::XLEN-1:0] memwb_val
    );
        case (sel)
            cpu_pkg::FWD_EXMEM: return exmem_val;
            cpu_pkg::FWD_MEMWB: return memwb_val;
            default:            return rf_val;
        endcase
    endfunction

    assign op_a     = pick(ex_fwd_a_i, ex_rs1_data_i, mem_result_o, wb_data_i);
    assign op_b_reg = pick(ex_fwd_b_i, ex_rs2_data_i, mem_result_o, wb_data_i);
    assign op_b     = ex_ctrl_i.use_imm ? ex_imm_i : op_b_reg;

    always_comb begin
        case (ex_ctrl_i.alu_op)
            cpu_pkg::ALU_SUB: alu_res = op_a - op_b;
            cpu_pkg::ALU_AND: alu_res = op_a & op_b;
            cpu_pkg::ALU_OR:  alu_res = op_a | op_b;
            cpu_pkg::ALU_XOR: alu_res = op_a ^ op_b;
            cpu_pkg::ALU_SLT: alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            default:          alu_res = op_a + op_b;
        endcase
    end

    // BEQ/BNE resolved here, two younger slots get flushed
    assign ctrl.redirect        = ex_ctrl_i.branch &&
                                  ((op_a == op_b_reg) != ex_ctrl_i.branch_ne);
    assign ctrl.redirect_target = ex_pc_i + ex_imm_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_ctrl_o <= '0;
        end else begin
            mem_ctrl_o <= ex_ctrl_i;
        end
    end

    always_ff @(posedge clk) begin
        mem_result_o     <= alu_res;
        mem_store_data_o <= op_b_reg;
        mem_rd_o         <= ex_rd_i;
    end

endmodule

`default_nettype wire

/* design/fetch_stage.sv */
`default_nettype none

module fetch_stage (
    input  wire                      clk,
    input  wire                      rst_n_i,
    pipe_ctrl_if.fetch               ctrl,
    input  wire  [cpu_pkg::XLEN-1:0] instr_i,
    output logic [cpu_pkg::XLEN-1:0] pc_o,
    output logic [cpu_pkg::XLEN-1:0] id_pc_o,
    output logic [cpu_pkg::XLEN-1:0] id_instr_o
);

    localparam logic [cpu_pkg::XLEN-1:0] PC_STEP = 4;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o <= '0;
        end else if (ctrl.redirect) begin
            pc_o <= ctrl.redirect_target;
        end else if (!ctrl.pc_stall) begin
            pc_o <= pc_o + PC_STEP;
        end
    end

    // IF/ID, squashed when a branch redirects
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_pc_o    <= '0;
            id_instr_o <= cpu_pkg::NOP_INSTR;
        end else if (ctrl.redirect) begin
            id_instr_o <= cpu_pkg::NOP_INSTR;
        end else if (!ctrl.pc_stall) begin
            id_pc_o    <= pc_o;
            id_instr_o <= instr_i;
        end
    end

endmodule

`default_nettype wire

/* design/hazard_unit.sv */
`default_nettype none

module hazard_unit (
    pipe_ctrl_if.hazard                    ctrl,
    input  wire  [cpu_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  wire  [cpu_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    input  wire                            use_rs1_i,
    input  wire                            use_rs2_i,
    input  wire  [cpu_pkg::REG_ADDR_W-1:0] ex_rd_i,
    input  wire                            ex_mem_read_i,
    input  wire                            ex_reg_write_i,
    input  wire  [cpu_pkg::REG_ADDR_W-1:0] mem_rd_i,
    input  wire                            mem_reg_write_i,
    output cpu_pkg::fwd_sel_e              fwd_a_o,
    output cpu_pkg::fwd_sel_e              fwd_b_o
);

    logic load_use;

    // Loaded data is not ready until the load leaves memory
    assign load_use = ex_mem_read_i && (ex_rd_i != '0) &&
                      ((use_rs1_i && ex_rd_i == rs1_addr_i) ||
                       (use_rs2_i && ex_rd_i == rs2_addr_i));

    assign ctrl.pc_stall     = load_use;
    assign ctrl.id_ex_bubble = load_use;

    // Selects are registered with the instruction, so the producer now in EX
    // will sit in EX/MEM and the one in MEM will be at write-back
    function automatic cpu_pkg::fwd_sel_e pick_src(
        input logic [cpu_pkg::REG_ADDR_W-1:0] rs,
        input logic                           used
    );
        if (!used || rs == '0) begin
            return cpu_pkg::FWD_REG;
        end
        if (ex_reg_write_i && ex_rd_i == rs) begin
            return cpu_pkg::FWD_EXMEM;
        end
        if (mem_reg_write_i && mem_rd_i == rs) begin
            return cpu_pkg::FWD_MEMWB;
        end
        return cpu_pkg::FWD_REG;
    endfunction

    always_comb begin
        fwd_a_o = pick_src(rs1_addr_i, use_rs1_i);
        fwd_b_o = pick_src(rs2_addr_i, use_rs2_i);
    end

endmodule

`default_nettype wire

/* design/memory_stage.sv */
`default_nettype none

module memory_stage #(
    parameter int DMEM_WORDS = 64
) (
    input  wire                            clk,
    input  wire                            rst_n_i,
    input  wire  [cpu_pkg::XLEN-1:0]       mem_result_i,
    input  wire  [cpu_pkg::XLEN-1:0]       mem_store_data_i,
    input  wire  [cpu_pkg::REG_ADDR_W-1:0] mem_rd_i,
    input  wire  cpu_pkg::ctrl_t           mem_ctrl_i,
    output logic                           wb_valid_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [cpu_pkg::XLEN-1:0]       wb_data_o
);

    // Needs at least two words
    localparam int IDX_W = $clog2(DMEM_WORDS);

    logic [cpu_pkg::XLEN-1:0] ram [DMEM_WORDS];
    logic [IDX_W-1:0]         idx;

    // Word address, upper bits wrap
    assign idx = mem_result_i[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (mem_ctrl_i.mem_write) begin
            ram[idx] <= mem_store_data_i;
        end
    end

    // MEM/WB
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= mem_ctrl_i.reg_write && (mem_rd_i != '0);
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o   <= mem_rd_i;
        wb_data_o <= mem_ctrl_i.mem_read ? ram[idx] : mem_result_i;
    end

endmodule

`default_nettype wire

/* design/pipe_ctrl_if.sv */
`default_nettype none

interface pipe_ctrl_if;

    logic                     pc_stall;
    logic                     id_ex_bubble;
    // Taken branch from execute, wins over a stall
    logic                     redirect;
    logic [cpu_pkg::XLEN-1:0] redirect_target;

    modport hazard (output pc_stall, output id_ex_bubble);

    modport execute (output redirect, output redirect_target);

    modport fetch (input pc_stall, input redirect, input redirect_target);

    modport decode (input id_ex_bubble, input redirect);

endinterface

`default_nettype wire

/* design/register_file.sv */
`default_nettype none

module register_file (
    input  wire                            clk,
    input  wire                            rst_n_i,
    input  wire  [cpu_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  wire  [cpu_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [cpu_pkg::XLEN-1:0]       rs1_data_o,
    output logic [cpu_pkg::XLEN-1:0]       rs2_data_o,
    input  wire                            we_i,
    input  wire  [cpu_pkg::REG_ADDR_W-1:0] rd_i,
    input  wire  [cpu_pkg::XLEN-1:0]       wd_i
);

    localparam int NREGS = 2 ** cpu_pkg::REG_ADDR_W;

    // No storage behind x0
    logic [cpu_pkg::XLEN-1:0] regs [1:NREGS-1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= wd_i;
        end
    end

    // Write-back in the same cycle shows through to decode
    assign rs1_data_o = (rs1_addr_i == '0)             ? '0   :
                        (we_i && rd_i == rs1_addr_i)   ? wd_i : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0)             ? '0   :
                        (we_i && rd_i == rs2_addr_i)   ? wd_i : regs[rs2_addr_i];

endmodule

`default_nettype wire

/* verification/tb_cpu_top.sv */
`default_nettype none

module tb_cpu_top;

    localparam int          PROG_LEN    = 60;
    localparam int          NUM_PROGS   = 3;
    // Four cycles per instruction plus drain, per program
    localparam int          CYCLE_LIMIT = NUM_PROGS * (PROG_LEN * 4 + 40);
    localparam logic [31:0] LOOP_ADDR   = (PROG_LEN - 1) * 4;
    localparam logic [31:0] NOP         = 32'h0000_0013;
    // BEQ x0, x0, 0
    localparam logic [31:0] SELF_LOOP   = 32'h0000_0063;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic [31:0] imem [64];
    // Programs only touch x0..x7
    logic [31:0] model_regs [8];
    logic [31:0] model_mem [64];
    logic        mem_valid [64];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];

    integer seed = 32'h07e8_322b;
    int     cycles = 0;
    int     checks = 0;
    int     value_errors = 0;
    int     other_errors = 0;

    cpu_top #(
        .DMEM_WORDS (64)
    ) i_cpu_top (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .imem_addr_o (imem_addr),
        .imem_data_i (imem_data),
        .wb_valid_o  (wb_valid),
        .wb_rd_o     (wb_rd),
        .wb_data_o   (wb_data)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Instruction memory, anything past the program reads as a NOP
    assign imem_data = (imem_addr < 32'd256) ? imem[imem_addr[7:2]] : NOP;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the programs did not finish within %0d cycles", CYCLE_LIMIT);
            print_counts();
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] sign_ext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic print_counts();
        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
    endtask

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("Error at time %0t: %s is %h, expected %h",
                     $time, what, got, exp);
        end
    endtask

    task automatic record_write(input logic [4:0] rd, input logic [31:0] value);
        // x0 stays zero and raises no strobe
        if (rd != 5'd0) begin
            model_regs[rd[2:0]] = value;
            exp_rd.push_back(rd);
            exp_data.push_back(value);
        end
    endtask

    // Random program built in step with the instruction-level model
    task automatic build_program();
        int          pc_idx;
        int          skip;
        logic [31:0] r;
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [11:0] mem_off;
        logic [12:0] boff;
        logic [5:0]  widx;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        wr;
        logic        st;
        logic        taken;
        pc_idx = 0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = NOP;
        end
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        exp_rd.delete();
        exp_data.delete();
        for (int k = 0; k < PROG_LEN - 1; k++) begin
            r       = $random(seed);
            rd      = {2'b00, r[2:0]};
            rs1     = {2'b00, r[5:3]};
            rs2     = {2'b00, r[8:6]};
            imm     = r[20:9];
            widx    = r[26:21];
            kind    = r[31:28];
            mem_off = {4'b0000, widx, 2'b00};
            boff    = r[27] ? 13'd12 : 13'd8;
            skip    = r[27] ? 3 : 2;
            // Loads only from words already stored
            if ((kind == 4'd10 || kind == 4'd11) && !mem_valid[widx]) begin
                kind = 4'd12;
            end
            // Branch targets stay inside the program
            if (kind >= 4'd14 && k > PROG_LEN - 4) begin
                kind = 4'd0;
            end
            a     = model_regs[rs1[2:0]];
            b     = model_regs[rs2[2:0]];
            res   = '0;
            wr    = 1'b0;
            st    = 1'b0;
            taken = 1'b0;
            case (kind)
                4'd4: begin
                    imem[k] = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
                    res     = a + b;
                    wr      = 1'b1;
                end
                4'd5: begin
                    imem[k] = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
                    res     = a - b;
                    wr      = 1'b1;
                end
                4'd6: begin
                    imem[k] = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
                    res     = a & b;
                    wr      = 1'b1;
                end
                4'd7: begin
                    imem[k] = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
                    res     = a | b;
                    wr      = 1'b1;
                end
                4'd8: begin
                    imem[k] = {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
                    res     = a ^ b;
                    wr      = 1'b1;
                end
                4'd9: begin
                    imem[k] = {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
                    res     = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    wr      = 1'b1;
                end
                4'd10, 4'd11: begin
                    // LW rd, off(x0)
                    imem[k] = {mem_off, 5'd0, 3'b010, rd, 7'b0000011};
                    res     = model_mem[widx];
                    wr      = 1'b1;
                end
                4'd12, 4'd13: begin
                    imem[k] = {mem_off[11:5], rs2, 5'd0, 3'b010, mem_off[4:0], 7'b0100011};
                    st      = 1'b1;
                end
                4'd14, 4'd15: begin
                    // Odd kind is BNE
                    imem[k] = {boff[12], boff[10:5], rs2, rs1, 2'b00, kind[0],
                               boff[4:1], boff[11], 7'b1100011};
                    taken   = ((a == b) != kind[0]);
                end
                default: begin
                    imem[k] = {imm, rs1, 3'b000, rd, 7'b0010011};
                    res     = a + sign_ext12(imm);
                    wr      = 1'b1;
                end
            endcase
            // Slots jumped over are encoded but never executed
            if (k == pc_idx) begin
                if (st) begin
                    model_mem[widx] = b;
                    mem_valid[widx] = 1'b1;
                end
                if (wr) begin
                    record_write(rd, res);
                end
                pc_idx = taken ? k + skip : k + 1;
            end
        end
        imem[PROG_LEN-1] = SELF_LOOP;
    endtask

    task automatic match_strobe();
        logic [4:0]  erd;
        logic [31:0] edata;
        if (exp_rd.size() == 0) begin
            $display("Extra write-back of x%0d = %h at time %0t, the model has no write left",
                     wb_rd, wb_data, $time);
            other_errors++;
        end else begin
            erd   = exp_rd.pop_front();
            edata = exp_data.pop_front();
            compare_value("write-back rd", {27'd0, wb_rd}, {27'd0, erd});
            compare_value("write-back data", wb_data, edata);
        end
    endtask

    task automatic run_program(input int prog);
        int loop_cycles;
        rst_n = 1'b0;
        build_program();
        repeat (8) @(posedge clk);
        #2;
        // Fetch starts at address zero with nothing in write-back
        compare_value("fetch address in reset", imem_addr, 32'd0);
        compare_value("write-back strobe in reset", {31'd0, wb_valid}, 32'd0);
        rst_n = 1'b1;
        loop_cycles = 0;
        // Drain for 20 cycles once fetch reaches the closing self-loop
        while (loop_cycles < 20) begin
            @(posedge clk);
            #2;
            if (wb_valid) begin
                match_strobe();
            end
            if (loop_cycles > 0 || imem_addr == LOOP_ADDR) begin
                loop_cycles++;
            end
        end
        if (exp_rd.size() != 0) begin
            $display("Program %0d: %0d expected register writes never left the core",
                     prog, exp_rd.size());
            other_errors++;
        end
    endtask

    initial begin
        // Data RAM keeps its contents across programs, and so does the model
        for (int i = 0; i < 64; i++) begin
            mem_valid[i] = 1'b0;
        end
        for (int p = 0; p < NUM_PROGS; p++) begin
            run_program(p);
        end
        print_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
